//--- logic/bakeryPkg.sv
// Bakery lock shared types

package bakeryPkg;

    // Program steps of one bakery process.
    // Four bits hold all eleven steps.
    typedef enum logic [3:0] {
        // Raise the choosing flag.
        stepIdle         = 4'd0,
        // Take a ticket one above the largest in use.
        stepDraw         = 4'd1,
        // Lower the choosing flag.
        stepChosen       = 4'd2,
        // Restart the peer scan at index zero.
        stepScanStart    = 4'd3,
        // Leave the scan once every peer was checked.
        stepScanTest     = 4'd4,
        // Spin while the peer is still choosing.
        stepWaitChoosing = 4'd5,
        // Spin while the peer holds a better ticket.
        stepWaitTicket   = 4'd6,
        // Step the scan index to the next peer.
        stepScanNext     = 4'd7,
        // Inside the critical section, held by pause.
        stepCritical     = 4'd8,
        // Give the ticket back.
        stepRelease      = 4'd9,
        // Idle, held by pause.
        stepRest         = 4'd10
    } bakeryStep_t;

endpackage

//--- logic/ticketBus.sv
// Sequencer to ticket store bus

`timescale 1ns/100ps

interface ticketBus #(
    parameter int processCount = 3
);

    // Wide enough to hold the value processCount.
    localparam int indexWidth = $clog2(processCount + 1);

    // Process stepped on this edge.
    logic [indexWidth - 1:0] owner;
    // Single-cycle strobes, at most one per cycle.
    logic setChoosing;
    logic clearChoosing;
    logic drawTicket;
    logic dropTicket;
    // Peer being checked by the owner's scan.
    logic [indexWidth - 1:0] peerIndex;

    // Combinational replies about peerIndex.
    logic peerChoosing;
    logic peerAhead;

    modport sequencer (
        output owner,
        output setChoosing,
        output clearChoosing,
        output drawTicket,
        output dropTicket,
        output peerIndex,
        input  peerChoosing,
        input  peerAhead
    );

    modport store (
        input  owner,
        input  setChoosing,
        input  clearChoosing,
        input  drawTicket,
        input  dropTicket,
        input  peerIndex,
        output peerChoosing,
        output peerAhead
    );

endinterface

//--- logic/ticketStore.sv
// Ticket and choosing flag store

`timescale 1ns/100ps

module ticketStore #(
    parameter int processCount = 3,
    parameter int ticketWidth  = 8
) (
    input  logic clock,
    input  logic reset,
    ticketBus.store bus,
    output logic [processCount - 1:0] choosingMask,
    output logic [processCount * ticketWidth - 1:0] tickets
);

    localparam int indexWidth = $clog2(processCount + 1);

    // One ticket per process, zero means no ticket held.
    logic [ticketWidth - 1:0] ticketArray [processCount];
    // One choosing flag per process.
    logic [processCount - 1:0] choosing;

    // Values read out for the owner and the peer.
    logic [ticketWidth - 1:0] ownerTicket;
    logic [ticketWidth - 1:0] peerTicket;
    logic                     peerFlag;
    logic                     peerValid;
    // Largest ticket currently held.
    logic [ticketWidth - 1:0] maxTicket;

    // Owner and peer lookup.
    // A scan index equal to processCount names no process.
    always_comb begin
        ownerTicket = '0;
        peerTicket  = '0;
        peerFlag    = 1'b0;
        for (int p = 0; p < processCount; p++) begin
            if (indexWidth'(p) == bus.owner) begin
                ownerTicket = ticketArray[p];
            end
            if (indexWidth'(p) == bus.peerIndex) begin
                peerTicket = ticketArray[p];
                peerFlag   = choosing[p];
            end
        end
    end

    assign peerValid = bus.peerIndex < indexWidth'(processCount);

    // Largest ticket over all processes.
    always_comb begin
        maxTicket = '0;
        for (int p = 0; p < processCount; p++) begin
            if (ticketArray[p] > maxTicket) begin
                maxTicket = ticketArray[p];
            end
        end
    end

    // Replies to the scanning owner.
    assign bus.peerChoosing = peerValid && peerFlag;

    // Peer wins with a lower ticket.
    // Equal tickets go to the lower index.
    assign bus.peerAhead = peerValid && (peerTicket != '0) &&
                           ((peerTicket < ownerTicket) ||
                            ((peerTicket == ownerTicket) && (bus.peerIndex < bus.owner)));

    // Only the owner's entries change.
    always_ff @(posedge clock) begin
        if (reset) begin
            choosing <= '0;
            for (int p = 0; p < processCount; p++) begin
                ticketArray[p] <= '0;
            end
        end else begin
            for (int p = 0; p < processCount; p++) begin
                if (indexWidth'(p) == bus.owner) begin
                    if (bus.setChoosing) begin
                        choosing[p] <= 1'b1;
                    end
                    if (bus.clearChoosing) begin
                        choosing[p] <= 1'b0;
                    end
                    // Wraps at the top value.
                    if (bus.drawTicket) begin
                        ticketArray[p] <= maxTicket + ticketWidth'(1);
                    end
                    if (bus.dropTicket) begin
                        ticketArray[p] <= '0;
                    end
                end
            end
        end
    end

    // Flat outputs, process 0 in the low bits.
    assign choosingMask = choosing;

    always_comb begin
        for (int p = 0; p < processCount; p++) begin
            tickets[p * ticketWidth +: ticketWidth] = ticketArray[p];
        end
    end

endmodule

//--- logic/scanCounter.sv
// Per-process peer scan counter

`timescale 1ns/100ps

module scanCounter #(
    parameter int processCount = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic [$clog2(processCount + 1) - 1:0] owner,
    input  logic clearScan,
    input  logic advanceScan,
    output logic [$clog2(processCount + 1) - 1:0] scanIndex,
    output logic scanDone
);

    localparam int indexWidth = $clog2(processCount + 1);

    // One scan index per process.
    // Runs from 0 up to processCount.
    logic [indexWidth - 1:0] indexArray [processCount];

    // Owner's index, read combinationally.
    always_comb begin
        scanIndex = '0;
        for (int p = 0; p < processCount; p++) begin
            if (indexWidth'(p) == owner) begin
                scanIndex = indexArray[p];
            end
        end
    end

    // Every peer, the owner included, was checked.
    assign scanDone = scanIndex == indexWidth'(processCount);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < processCount; p++) begin
                indexArray[p] <= '0;
            end
        end else begin
            for (int p = 0; p < processCount; p++) begin
                if (indexWidth'(p) == owner) begin
                    // Clear wins, the two never meet anyway.
                    if (clearScan) begin
                        indexArray[p] <= '0;
                    end else if (advanceScan) begin
                        indexArray[p] <= indexArray[p] + indexWidth'(1);
                    end
                end
            end
        end
    end

endmodule

//--- logic/processSequencer.sv
// Bakery process step sequencer

`timescale 1ns/100ps

module processSequencer #(
    parameter int processCount = 3
) (
    input  logic clock,
    input  logic reset,
    input  logic [$clog2(processCount + 1) - 1:0] select,
    input  logic pause,
    ticketBus.sequencer bus,
    input  logic [$clog2(processCount + 1) - 1:0] scanIndex,
    input  logic scanDone,
    output logic [$clog2(processCount + 1) - 1:0] owner,
    output logic clearScan,
    output logic advanceScan,
    output logic [processCount - 1:0] criticalMask
);

    import bakeryPkg::*;

    localparam int indexWidth = $clog2(processCount + 1);

    // Program step of every process.
    bakeryStep_t stepArray [processCount];
    // Owner's step now and after this edge.
    bakeryStep_t currentStep;
    bakeryStep_t nextStep;

    // Out-of-range select falls back to process 0.
    always_comb begin
        if (select >= indexWidth'(processCount)) begin
            owner = '0;
        end else begin
            owner = select;
        end
    end

    always_comb begin
        currentStep = stepIdle;
        for (int p = 0; p < processCount; p++) begin
            if (indexWidth'(p) == owner) begin
                currentStep = stepArray[p];
            end
        end
    end

    // Store and counter see the owner and its scan position.
    assign bus.owner     = owner;
    assign bus.peerIndex = scanIndex;

    // Strobes and next step of the owner.
    // A waiting step loops onto itself.
    always_comb begin
        bus.setChoosing   = 1'b0;
        bus.clearChoosing = 1'b0;
        bus.drawTicket    = 1'b0;
        bus.dropTicket    = 1'b0;
        clearScan         = 1'b0;
        advanceScan       = 1'b0;
        nextStep          = currentStep;
        case (currentStep)
            stepIdle: begin
                bus.setChoosing = 1'b1;
                nextStep        = stepDraw;
            end
            stepDraw: begin
                bus.drawTicket = 1'b1;
                nextStep       = stepChosen;
            end
            stepChosen: begin
                bus.clearChoosing = 1'b1;
                nextStep          = stepScanStart;
            end
            stepScanStart: begin
                clearScan = 1'b1;
                nextStep  = stepScanTest;
            end
            stepScanTest: begin
                nextStep = scanDone ? stepCritical : stepWaitChoosing;
            end
            stepWaitChoosing: begin
                nextStep = bus.peerChoosing ? stepWaitChoosing : stepWaitTicket;
            end
            stepWaitTicket: begin
                nextStep = bus.peerAhead ? stepWaitTicket : stepScanNext;
            end
            stepScanNext: begin
                advanceScan = 1'b1;
                nextStep    = stepScanTest;
            end
            stepCritical: begin
                nextStep = pause ? stepCritical : stepRelease;
            end
            stepRelease: begin
                bus.dropTicket = 1'b1;
                nextStep       = stepRest;
            end
            stepRest: begin
                nextStep = pause ? stepRest : stepIdle;
            end
            // Unused encodings recover to idle.
            default: begin
                nextStep = stepIdle;
            end
        endcase
    end

    // Only the owner moves on each edge.
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < processCount; p++) begin
                stepArray[p] <= stepIdle;
            end
        end else begin
            for (int p = 0; p < processCount; p++) begin
                if (indexWidth'(p) == owner) begin
                    stepArray[p] <= nextStep;
                end
            end
        end
    end

    // Decoded straight from the step registers.
    always_comb begin
        for (int p = 0; p < processCount; p++) begin
            criticalMask[p] = stepArray[p] == stepCritical;
        end
    end

endmodule

//--- logic/bakeryArbiter.sv
// Bakery mutual exclusion arbiter

`timescale 1ns/100ps

module bakeryArbiter #(
    parameter int processCount = 3,
    parameter int ticketWidth  = 8
) (
    input  logic clock,
    input  logic reset,
    // Process to step on this edge.
    input  logic [$clog2(processCount + 1) - 1:0] select,
    // Holds a process in its critical or rest step.
    input  logic pause,
    output logic [processCount - 1:0] criticalMask,
    output logic [processCount - 1:0] choosingMask,
    output logic [processCount * ticketWidth - 1:0] tickets
);

    localparam int indexWidth = $clog2(processCount + 1);

    // Sequencer to counter wires.
    logic [indexWidth - 1:0] owner;
    logic                    clearScan;
    logic                    advanceScan;
    logic [indexWidth - 1:0] scanIndex;
    logic                    scanDone;

    ticketBus #(
        .processCount(processCount)
    ) bus ();

    processSequencer #(
        .processCount(processCount)
    ) sequencer (
        .clock       (clock),
        .reset       (reset),
        .select      (select),
        .pause       (pause),
        .bus         (bus.sequencer),
        .scanIndex   (scanIndex),
        .scanDone    (scanDone),
        .owner       (owner),
        .clearScan   (clearScan),
        .advanceScan (advanceScan),
        .criticalMask(criticalMask)
    );

    scanCounter #(
        .processCount(processCount)
    ) counter (
        .clock      (clock),
        .reset      (reset),
        .owner      (owner),
        .clearScan  (clearScan),
        .advanceScan(advanceScan),
        .scanIndex  (scanIndex),
        .scanDone   (scanDone)
    );

    ticketStore #(
        .processCount(processCount),
        .ticketWidth (ticketWidth)
    ) store (
        .clock       (clock),
        .reset       (reset),
        .bus         (bus.store),
        .choosingMask(choosingMask),
        .tickets     (tickets)
    );

endmodule

//--- tb/bakeryArbiter_props.sv
// Bakery arbiter properties

`timescale 1ns/100ps

module bakeryArbiterProps #(
    parameter int processCount = 3,
    parameter int ticketWidth  = 8
) (
    input logic clock,
    input logic reset,
    input logic pause,
    input logic [processCount - 1:0] criticalMask,
    input logic [processCount - 1:0] choosingMask,
    input logic [processCount * ticketWidth - 1:0] tickets
);

    // Failed assertions so far, read by the testbench.
    int violationCount = 0;

    // Tickets split per process, process 0 in the low bits.
    logic [processCount - 1:0][ticketWidth - 1:0] ticketOf;
    // Largest ticket held, and the value a draw must take.
    logic [ticketWidth - 1:0] maxTicket;
    logic [ticketWidth - 1:0] drawValue;

    assign ticketOf = tickets;

    always_comb begin
        maxTicket = '0;
        for (int p = 0; p < processCount; p++) begin
            if (ticketOf[p] > maxTicket) begin
                maxTicket = ticketOf[p];
            end
        end
    end

    assign drawValue = maxTicket + ticketWidth'(1);

    // At most one process in the critical section.
    mutualExclusion: assert property (@(posedge clock) disable iff (reset)
        $onehot0(criticalMask))
    else begin
        $error("more than one process in the critical section");
        violationCount++;
    end

    // Everything cleared on the first edge after reset.
    resetState: assert property (@(posedge clock)
        $fell(reset) |-> (criticalMask == '0) && (choosingMask == '0) && (tickets == '0))
    else begin
        $error("outputs not cleared by reset");
        violationCount++;
    end

    for (genvar p = 0; p < processCount; p++) begin : perProcess
        // A fresh ticket is one above the old maximum.
        drawRule: assert property (@(posedge clock) disable iff (reset)
            (($past(ticketOf[p]) == '0) && (ticketOf[p] != '0)) |->
                (ticketOf[p] == $past(drawValue)))
        else begin
            $error("process %0d drew a wrong ticket", p);
            violationCount++;
        end

        // Pause keeps a process inside.
        pauseHold: assert property (@(posedge clock) disable iff (reset)
            (criticalMask[p] && pause) |=> criticalMask[p])
        else begin
            $error("process %0d left the critical section under pause", p);
            violationCount++;
        end
    end

endmodule

// Attach to every arbiter.
bind bakeryArbiter bakeryArbiterProps #(
    .processCount(processCount),
    .ticketWidth (ticketWidth)
) props (
    .clock       (clock),
    .reset       (reset),
    .pause       (pause),
    .criticalMask(criticalMask),
    .choosingMask(choosingMask),
    .tickets     (tickets)
);

//--- tb/bakeryTb.sv
// Bakery arbiter testbench

`timescale 1ns/100ps

module bakeryTb;

    localparam int processCount = 3;
    localparam int ticketWidth  = 8;
    localparam int indexWidth   = $clog2(processCount + 1);

    // Phase lengths in cycles.
    localparam int resetCycles  = 5;
    localparam int clampCycles  = 80;
    localparam int randomCycles = 800;
    localparam int pauseCycles  = 400;
    // All phases plus some slack.
    localparam int cycleLimit = resetCycles + clampCycles + randomCycles + pauseCycles + 200;

    // Stimulus modes.
    localparam int clampMode  = 0;
    localparam int randomMode = 1;
    localparam int pauseMode  = 2;

    logic                                  clock = 1'b0;
    logic                                  reset;
    logic [indexWidth - 1:0]               select;
    logic                                  pause;
    logic [processCount - 1:0]             criticalMask;
    logic [processCount - 1:0]             choosingMask;
    logic [processCount * ticketWidth - 1:0] tickets;

    logic [31:0]               rngState = 32'h3a4a_8255;
    int                        cycleCount = 0;
    int                        checkCount = 0;
    int                        errorCount = 0;
    // Process stepped on the last edge.
    int                        lastOwner = 0;
    logic [processCount - 1:0] prevCritical = '0;
    // Left the critical section, ticket drop still due.
    logic [processCount - 1:0] pendingRelease = '0;
    // Critical section entries in the current phase.
    int                        entryCount [processCount];

    bakeryArbiter #(
        .processCount(processCount),
        .ticketWidth (ticketWidth)
    ) DUT (
        .clock       (clock),
        .reset       (reset),
        .select      (select),
        .pause       (pause),
        .criticalMask(criticalMask),
        .choosingMask(choosingMask),
        .tickets     (tickets)
    );

    always #50 clock = ~clock;

    // Hang guard.
    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Out-of-range select steps process 0.
    function automatic int ownerOf(input logic [indexWidth - 1:0] value);
        if (int'(value) >= processCount) begin
            return 0;
        end
        return int'(value);
    endfunction

    // Samples the outputs of the last edge.
    task automatic checkEdge();
        logic [ticketWidth - 1:0] ticketValue;
        for (int p = 0; p < processCount; p++) begin
            ticketValue = tickets[p * ticketWidth +: ticketWidth];
            // The step after leaving drops the ticket.
            if (pendingRelease[p] && lastOwner == p) begin
                checkCount++;
                assert (ticketValue == '0) else begin
                    $display("FAIL at %0t: process %0d still holds ticket %0d after release",
                             $time, p, ticketValue);
                    errorCount++;
                end
                pendingRelease[p] = 1'b0;
            end
            if (prevCritical[p] && !criticalMask[p]) begin
                pendingRelease[p] = 1'b1;
            end
            if (!prevCritical[p] && criticalMask[p]) begin
                entryCount[p]++;
            end
        end
        prevCritical = criticalMask;
    endtask

    task automatic runPhase(input string phaseName, input int cycles, input int mode);
        int                      errorsBefore;
        int                      violationsBefore;
        logic [indexWidth - 1:0] selectValue;
        logic                    pauseValue;
        string                   entries;
        errorsBefore     = errorCount;
        violationsBefore = DUT.props.violationCount;
        entries          = "";
        for (int p = 0; p < processCount; p++) begin
            entryCount[p] = 0;
        end
        for (int c = 0; c < cycles; c++) begin
            rngState   = nextRandom(rngState);
            pauseValue = 1'b0;
            if (mode == clampMode) begin
                // Pick among the values at or above processCount.
                selectValue = indexWidth'(processCount +
                    int'(rngState[23:16]) % ((1 << indexWidth) - processCount));
            end else begin
                selectValue = rngState[16 +: indexWidth];
            end
            if (mode == pauseMode) begin
                pauseValue = rngState[28];
            end
            select    = selectValue;
            pause     = pauseValue;
            lastOwner = ownerOf(selectValue);
            @(negedge clock);
            checkEdge();
        end
        // Progress, or only process 0 under clamping.
        for (int p = 0; p < processCount; p++) begin
            entries = {entries, $sformatf(" %0d", entryCount[p])};
            if (mode == clampMode && p != 0) begin
                checkCount++;
                assert (entryCount[p] == 0) else begin
                    $display("FAIL at %0t: process %0d entered with out-of-range select",
                             $time, p);
                    errorCount++;
                end
            end else if (mode != pauseMode) begin
                checkCount++;
                assert (entryCount[p] > 0) else begin
                    $display("FAIL at %0t: process %0d never entered the critical section",
                             $time, p);
                    errorCount++;
                end
            end
        end
        $display("Phase %s: %s, entries%s", phaseName,
                 (errorCount == errorsBefore && DUT.props.violationCount == violationsBefore)
                     ? "passed" : "failed", entries);
    endtask

    initial begin
        reset  = 1'b1;
        select = '0;
        pause  = 1'b0;
        repeat (resetCycles) @(negedge clock);
        reset = 1'b0;
        // First edge out of reset, reset values checked by the properties.
        lastOwner = 0;
        @(negedge clock);
        checkEdge();
        $display("Phase reset: %s", (DUT.props.violationCount == 0) ? "passed" : "failed");

        // Clamping first, while every peer is still idle.
        runPhase("clamp", clampCycles, clampMode);
        runPhase("random", randomCycles, randomMode);
        runPhase("pause", pauseCycles, pauseMode);

        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checkCount, errorCount, DUT.props.violationCount);
        if (errorCount == 0 && DUT.props.violationCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bakeryLock.f
logic/bakeryPkg.sv
logic/ticketBus.sv
logic/ticketStore.sv
logic/scanCounter.sv
logic/processSequencer.sv
logic/bakeryArbiter.sv
tb/bakeryArbiter_props.sv
tb/bakeryTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the bakeryLock simulation with Verilator.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBinary=bakerySim

verilator --binary --timing --assert -Wno-fatal \
    --top-module bakeryTb -f bakeryLock.f \
    --Mdir "$buildDir" -o "$simBinary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the error limit so the testbench can still print its summary.
output=$("./$buildDir/$simBinary" +verilator+error+limit+100 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST OK" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
